// File: pipe_pkg.sv
`default_nettype none

package pipe_pkg;

	localparam int word_width = 16;
	localparam int lane_count = 8;
	localparam int vector_width = 128;
	localparam int register_count = 32;
	localparam int memory_depth = 256;

	localparam int lane_bits = $clog2(lane_count);
	localparam int memory_index_bits = $clog2(memory_depth);
	localparam int register_index_bits = $clog2(register_count);

	typedef logic [word_width-1:0] scalar_t;
	typedef logic [vector_width-1:0] vector_t;
	typedef logic [register_index_bits-1:0] register_index_t;

	// Upper bits pick the word, low bits pick the 16-bit lane inside it
	typedef logic [word_width-1:0] memory_address_t;
	typedef logic [lane_bits-1:0] lane_index_t;
	typedef logic [memory_index_bits-1:0] memory_index_t;

	typedef logic [1:0] scalar_select_t;
	localparam scalar_select_t scalar_select_calc = 2'd0;
	localparam scalar_select_t scalar_select_memory = 2'd1;
	localparam scalar_select_t scalar_select_vector_lane = 2'd2;
	localparam scalar_select_t scalar_select_reserved = 2'd3;

	typedef logic [1:0] vector_select_t;
	localparam vector_select_t vector_select_calc = 2'd0;
	localparam vector_select_t vector_select_memory = 2'd1;
	localparam vector_select_t vector_select_broadcast = 2'd2;
	localparam vector_select_t vector_select_reserved = 2'd3;

	typedef struct packed {
		logic wre;
		logic vector_wre;
		scalar_select_t scalar_select;
		vector_select_t vector_select;
		logic mem_write;
		logic vector_mem_write;
		memory_address_t address;
		scalar_t store_data;
		vector_t store_vector;
		scalar_t calc_data;
		vector_t calc_vector;
		register_index_t rd;
	} mem_stage_t;

	typedef struct packed {
		logic wre;
		logic vector_wre;
		scalar_select_t scalar_select;
		vector_select_t vector_select;
		scalar_t load_data;
		vector_t load_vector;
		scalar_t calc_data;
		vector_t calc_vector;
		register_index_t rd;
	} wb_stage_t;

	typedef struct packed {
		logic wre;
		logic vector_wre;
		register_index_t rd;
		scalar_t scalar_result;
		vector_t vector_result;
	} wb_forward_t;

endpackage

`default_nettype wire

// File: data_memory.sv
`default_nettype none

module data_memory import pipe_pkg::*; (
	input wire logic clk,
	input wire logic reset,
	input wire memory_address_t address,
	input wire scalar_t store_data,
	input wire vector_t store_vector,
	input wire logic mem_write,
	input wire logic vector_mem_write,
	output scalar_t load_data,
	output vector_t load_vector
);

	vector_t memory [memory_depth];

	lane_index_t lane;
	memory_index_t word_index;

	// The word index wraps at the memory depth
	assign lane = address[lane_bits-1:0];
	assign word_index = address[lane_bits +: memory_index_bits];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < memory_depth; i++) begin
				memory[i] <= '0;
			end
		end else if (vector_mem_write) begin
			// A whole-word store overrides a lane store in the same cycle
			memory[word_index] <= store_vector;
		end else if (mem_write) begin
			memory[word_index][lane*word_width +: word_width] <= store_data;
		end
	end

	// Reads see the contents from before this cycle's store
	always_comb begin
		load_vector = memory[word_index];
		load_data = load_vector[lane*word_width +: word_width];
	end

endmodule

`default_nettype wire

// File: memory_writeback_register.sv
`default_nettype none

module memory_writeback_register import pipe_pkg::*; (
	input wire logic clk,
	input wire logic reset,
	input wire wb_stage_t memory_stage,
	output wb_stage_t writeback_stage
);

	// Loads every cycle, a cleared entry is a bubble since both write enables are low
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			writeback_stage <= '0;
		end else begin
			writeback_stage <= memory_stage;
		end
	end

endmodule

`default_nettype wire

// File: writeback_select.sv
`default_nettype none

module writeback_select import pipe_pkg::*; (
	input wire wb_stage_t stage,
	output scalar_t scalar_result,
	output vector_t vector_result
);

	always_comb begin
		case (stage.scalar_select)
			scalar_select_memory: begin
				scalar_result = stage.load_data;
			end
			scalar_select_vector_lane: begin
				scalar_result = stage.calc_vector[word_width-1:0];
			end
			scalar_select_calc, scalar_select_reserved: begin
				scalar_result = stage.calc_data;
			end
			default: begin
				scalar_result = stage.calc_data;
			end
		endcase
	end

	always_comb begin
		case (stage.vector_select)
			vector_select_memory: begin
				vector_result = stage.load_vector;
			end
			vector_select_broadcast: begin
				// Loaded lane copied into every lane
				vector_result = {lane_count{stage.load_data}};
			end
			vector_select_calc, vector_select_reserved: begin
				vector_result = stage.calc_vector;
			end
			default: begin
				vector_result = stage.calc_vector;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: scalar_register_file.sv
`default_nettype none

module scalar_register_file import pipe_pkg::*; (
	input wire logic clk,
	input wire logic reset,
	input wire logic write_enable,
	input wire register_index_t write_index,
	input wire scalar_t write_data,
	input wire register_index_t read_index_a,
	input wire register_index_t read_index_b,
	output scalar_t read_data_a,
	output scalar_t read_data_b
);

	scalar_t registers [register_count];

	logic write_allowed;

	// Register 0 is hardwired to zero, so writes to it are dropped
	assign write_allowed = write_enable && (write_index != '0);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < register_count; i++) begin
				registers[i] <= '0;
			end
		end else if (write_allowed) begin
			registers[write_index] <= write_data;
		end
	end

	assign read_data_a = registers[read_index_a];
	assign read_data_b = registers[read_index_b];

endmodule

`default_nettype wire

// File: vector_register_file.sv
`default_nettype none

module vector_register_file import pipe_pkg::*; (
	input wire logic clk,
	input wire logic reset,
	input wire logic write_enable,
	input wire register_index_t write_index,
	input wire vector_t write_data,
	input wire register_index_t read_index,
	output vector_t read_data
);

	vector_t registers [register_count];

	// Every entry is writable, register 0 included
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < register_count; i++) begin
				registers[i] <= '0;
			end
		end else if (write_enable) begin
			registers[write_index] <= write_data;
		end
	end

	assign read_data = registers[read_index];

endmodule

`default_nettype wire

// File: memory_writeback_unit.sv
`default_nettype none

module memory_writeback_unit import pipe_pkg::*; (
	input wire logic clk,
	input wire logic reset,
	input wire mem_stage_t mem_stage,
	input wire register_index_t scalar_read_index_a,
	input wire register_index_t scalar_read_index_b,
	input wire register_index_t vector_read_index,
	output scalar_t scalar_read_data_a,
	output scalar_t scalar_read_data_b,
	output vector_t vector_read_data,
	output wb_forward_t writeback
);

	scalar_t load_data;
	vector_t load_vector;
	wb_stage_t memory_stage;
	wb_stage_t writeback_stage;
	scalar_t scalar_result;
	vector_t vector_result;

	data_memory data_memory_inst (
		.clk(clk),
		.reset(reset),
		.address(mem_stage.address),
		.store_data(mem_stage.store_data),
		.store_vector(mem_stage.store_vector),
		.mem_write(mem_stage.mem_write),
		.vector_mem_write(mem_stage.vector_mem_write),
		.load_data(load_data),
		.load_vector(load_vector)
	);

	// Memory stage control plus the loaded values go into the pipeline register
	assign memory_stage = '{
		wre: mem_stage.wre,
		vector_wre: mem_stage.vector_wre,
		scalar_select: mem_stage.scalar_select,
		vector_select: mem_stage.vector_select,
		load_data: load_data,
		load_vector: load_vector,
		calc_data: mem_stage.calc_data,
		calc_vector: mem_stage.calc_vector,
		rd: mem_stage.rd
	};

	memory_writeback_register memory_writeback_register_inst (
		.clk(clk),
		.reset(reset),
		.memory_stage(memory_stage),
		.writeback_stage(writeback_stage)
	);

	writeback_select writeback_select_inst (
		.stage(writeback_stage),
		.scalar_result(scalar_result),
		.vector_result(vector_result)
	);

	scalar_register_file scalar_register_file_inst (
		.clk(clk),
		.reset(reset),
		.write_enable(writeback_stage.wre),
		.write_index(writeback_stage.rd),
		.write_data(scalar_result),
		.read_index_a(scalar_read_index_a),
		.read_index_b(scalar_read_index_b),
		.read_data_a(scalar_read_data_a),
		.read_data_b(scalar_read_data_b)
	);

	vector_register_file vector_register_file_inst (
		.clk(clk),
		.reset(reset),
		.write_enable(writeback_stage.vector_wre),
		.write_index(writeback_stage.rd),
		.write_data(vector_result),
		.read_index(vector_read_index),
		.read_data(vector_read_data)
	);

	// Writeback result for the forwarding logic of the wider pipeline
	assign writeback = '{
		wre: writeback_stage.wre,
		vector_wre: writeback_stage.vector_wre,
		rd: writeback_stage.rd,
		scalar_result: scalar_result,
		vector_result: vector_result
	};

endmodule

`default_nettype wire

// File: tb_memory_writeback_unit.sv
`default_nettype none

module tb_memory_writeback_unit import pipe_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int edge_timeout_ns = 100;
	localparam mem_stage_t bubble = '0;

	logic clk;
	logic reset;
	mem_stage_t mem_stage;
	register_index_t scalar_read_index_a;
	register_index_t scalar_read_index_b;
	register_index_t vector_read_index;
	scalar_t scalar_read_data_a;
	scalar_t scalar_read_data_b;
	vector_t vector_read_data;
	wb_forward_t writeback;

	vector_t model_memory [memory_depth];
	scalar_t model_scalar [register_count];
	vector_t model_vector [register_count];

	// Writeback that the register files take at the next rising edge
	wb_forward_t pending;

	logic [31:0] rng_state;
	int error_count;
	int check_count;

	memory_writeback_unit memory_writeback_unit_inst (
		.clk(clk),
		.reset(reset),
		.mem_stage(mem_stage),
		.scalar_read_index_a(scalar_read_index_a),
		.scalar_read_index_b(scalar_read_index_b),
		.vector_read_index(vector_read_index),
		.scalar_read_data_a(scalar_read_data_a),
		.scalar_read_data_b(scalar_read_data_b),
		.vector_read_data(vector_read_data),
		.writeback(writeback)
	);

	always #4 clk = ~clk;

	function automatic logic [31:0] next_random();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	function automatic vector_t random_vector();
		return {next_random(), next_random(), next_random(), next_random()};
	endfunction

	// The top address bits are random noise that the word index ignores
	function automatic memory_address_t lane_address(input logic [7:0] word, input logic [2:0] lane);
		logic [31:0] r;
		r = next_random();
		return {r[4:0], word, lane};
	endfunction

	function automatic wb_forward_t expected_writeback(input mem_stage_t s);
		vector_t old_word;
		scalar_t old_lane;
		wb_forward_t e;
		old_word = model_memory[s.address[10:3]];
		old_lane = old_word[s.address[2:0]*16 +: 16];
		e.wre = s.wre;
		e.vector_wre = s.vector_wre;
		e.rd = s.rd;
		case (s.scalar_select)
			2'd1: e.scalar_result = old_lane;
			2'd2: e.scalar_result = s.calc_vector[15:0];
			default: e.scalar_result = s.calc_data;
		endcase
		case (s.vector_select)
			2'd1: e.vector_result = old_word;
			2'd2: e.vector_result = {8{old_lane}};
			default: e.vector_result = s.calc_vector;
		endcase
		return e;
	endfunction

	function automatic void apply_store(input mem_stage_t s);
		if (s.vector_mem_write) begin
			model_memory[s.address[10:3]] = s.store_vector;
		end else if (s.mem_write) begin
			model_memory[s.address[10:3]][s.address[2:0]*16 +: 16] = s.store_data;
		end
	endfunction

	function automatic void commit(input wb_forward_t e);
		if (e.wre && e.rd != 0) begin
			model_scalar[e.rd] = e.scalar_result;
		end
		if (e.vector_wre) begin
			model_vector[e.rd] = e.vector_result;
		end
	endfunction

	function automatic mem_stage_t random_stage();
		logic [31:0] r1;
		logic [31:0] r2;
		mem_stage_t s;
		r1 = next_random();
		r2 = next_random();
		// Both enables low in about a quarter of the cycles gives the bubbles
		s.wre = r1[2];
		s.vector_wre = r1[3];
		s.scalar_select = r1[5:4];
		s.vector_select = r1[7:6];
		s.mem_write = r1[8];
		s.vector_mem_write = r1[9] & r1[10];
		s.address = lane_address({6'b0, r1[12:11]}, r1[15:13]);
		s.store_data = r2[15:0];
		s.store_vector = random_vector();
		s.calc_data = r2[31:16];
		s.calc_vector = random_vector();
		s.rd = r1[20:16];
		return s;
	endfunction

	task automatic report_timeout(input string what);
		$display("Timeout: %s within %0d ns at %0d ns", what, edge_timeout_ns, $time);
		$display("Checks run: %0d, errors: %0d", check_count, error_count);
		$display("STATUS: FAIL");
		$finish;
	endtask

	task automatic wait_falling_edge();
		realtime start;
		start = $realtime;
		fork
			@(negedge clk);
			#(edge_timeout_ns);
		join_any
		disable fork;
		if ($realtime - start >= edge_timeout_ns) begin
			report_timeout("no falling clock edge");
		end
	endtask

	task automatic check_scalar(input string what, input scalar_t got, input scalar_t expected);
		check_count++;
		assert (got === expected) else begin
			error_count++;
			$display("Error at %0d ns: %s is %h, expected %h", $time, what, got, expected);
		end
	endtask

	task automatic check_vector(input string what, input vector_t got, input vector_t expected);
		check_count++;
		assert (got === expected) else begin
			error_count++;
			$display("Error at %0d ns: %s is %h, expected %h", $time, what, got, expected);
		end
	endtask

	task automatic check_writeback(input wb_forward_t expected);
		check_count++;
		assert (writeback === expected) else begin
			error_count++;
			$display("Error at %0d ns: writeback wre=%b vector_wre=%b rd=%0d scalar=%h vector=%h",
				$time, writeback.wre, writeback.vector_wre, writeback.rd,
				writeback.scalar_result, writeback.vector_result);
			$display("    expected wre=%b vector_wre=%b rd=%0d scalar=%h vector=%h",
				expected.wre, expected.vector_wre, expected.rd,
				expected.scalar_result, expected.vector_result);
		end
	endtask

	// Drives one instruction and checks its writeback one edge later
	task automatic issue(input mem_stage_t s);
		wb_forward_t expected;
		expected = expected_writeback(s);
		mem_stage = s;
		wait_falling_edge();
		commit(pending);
		apply_store(s);
		check_writeback(expected);
		pending = expected;
	endtask

	// Between two rising edges the register files hold exactly the committed model
	task automatic compare_read_ports(input register_index_t index);
		scalar_read_index_a = index;
		scalar_read_index_b = 5'd31 - index;
		vector_read_index = index;
		#1;
		check_scalar($sformatf("scalar register %0d", index),
			scalar_read_data_a, model_scalar[index]);
		check_scalar($sformatf("scalar register %0d", 5'd31 - index),
			scalar_read_data_b, model_scalar[5'd31 - index]);
		check_vector($sformatf("vector register %0d", index),
			vector_read_data, model_vector[index]);
	endtask

	// The wait issues nothing, so the pipeline must already hold a bubble
	task automatic check_read_ports(input register_index_t index);
		compare_read_ports(index);
		wait_falling_edge();
	endtask

	task automatic check_registers();
		issue(bubble);
		for (int i = 0; i < register_count; i++) begin
			check_read_ports(i);
		end
	endtask

	task automatic test_reset();
		reset = 1'b1;
		for (int i = 0; i < 10; i++) begin
			wait_falling_edge();
		end
		check_writeback('0);
		reset = 1'b0;
		check_registers();
	endtask

	task automatic test_calc_writeback();
		logic [31:0] r;
		mem_stage_t s;
		for (int i = 0; i < 12; i++) begin
			r = next_random();
			s = bubble;
			s.wre = 1'b1;
			s.vector_wre = 1'b1;
			s.rd = (i == 0) ? 5'd0 : r[4:0];
			s.calc_data = r[31:16];
			s.calc_vector = random_vector();
			issue(s);
			// The register files take the write only at the next rising edge
			mem_stage = bubble;
			compare_read_ports(s.rd);
			check_writeback(pending);
			issue(bubble);
			check_read_ports(s.rd);
		end
	endtask

	task automatic test_store_load();
		logic [31:0] r;
		logic [7:0] word;
		mem_stage_t s;
		r = next_random();
		word = r[7:0];
		s = bubble;
		s.vector_mem_write = 1'b1;
		s.address = lane_address(word, 3'd0);
		s.store_vector = random_vector();
		issue(s);
		// Each lane store also loads the same lane, which must return the old value
		for (int k = 0; k < 2; k++) begin
			r = next_random();
			s = bubble;
			s.mem_write = 1'b1;
			s.wre = 1'b1;
			s.scalar_select = 2'd1;
			s.address = lane_address(word, (k == 0) ? 3'd2 : 3'd5);
			s.store_data = r[15:0];
			s.rd = 5'd1 + k;
			issue(s);
		end
		for (int lane = 0; lane < lane_count; lane++) begin
			s = bubble;
			s.wre = 1'b1;
			s.scalar_select = 2'd1;
			s.address = lane_address(word, lane);
			s.rd = 5'd8 + lane;
			issue(s);
		end
		s = bubble;
		s.vector_wre = 1'b1;
		s.vector_select = 2'd1;
		s.address = lane_address(word, 3'd3);
		s.rd = 5'd20;
		issue(s);
		s.vector_mem_write = 1'b1;
		s.store_vector = random_vector();
		s.rd = 5'd21;
		issue(s);
		s.vector_mem_write = 1'b0;
		s.rd = 5'd22;
		issue(s);
		check_registers();
	endtask

	task automatic test_select_modes();
		logic [31:0] r;
		mem_stage_t s;
		s = bubble;
		s.vector_mem_write = 1'b1;
		s.address = lane_address(8'd7, 3'd0);
		s.store_vector = random_vector();
		issue(s);
		for (int i = 0; i < 8; i++) begin
			r = next_random();
			s = bubble;
			s.wre = 1'b1;
			s.vector_wre = 1'b1;
			s.scalar_select = (i % 2 == 0) ? 2'd2 : 2'd3;
			s.vector_select = (i < 4) ? 2'd2 : 2'd3;
			s.address = lane_address(8'd7, r[2:0]);
			s.calc_data = r[31:16];
			s.calc_vector = random_vector();
			s.rd = r[12:8];
			issue(s);
		end
		check_registers();
	endtask

	task automatic test_back_to_back();
		for (int i = 0; i < 64; i++) begin
			issue(random_stage());
		end
		check_registers();
	endtask

	initial begin
		rng_state = 32'h10ee;
		error_count = 0;
		check_count = 0;
		pending = '0;
		for (int i = 0; i < memory_depth; i++) begin
			model_memory[i] = '0;
		end
		for (int i = 0; i < register_count; i++) begin
			model_scalar[i] = '0;
			model_vector[i] = '0;
		end
		clk = 1'b0;
		reset = 1'b1;
		mem_stage = bubble;
		scalar_read_index_a = '0;
		scalar_read_index_b = '0;
		vector_read_index = '0;

		test_reset();
		test_calc_writeback();
		test_store_load();
		test_select_modes();
		test_back_to_back();

		$display("Checks run: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: all.f
pipe_pkg.sv
data_memory.sv
memory_writeback_register.sv
writeback_select.sv
scalar_register_file.sv
vector_register_file.sv
memory_writeback_unit.sv
tb_memory_writeback_unit.sv
